// File: hw/tetris_ai_defs.svh
`ifndef TETRIS_AI_DEFS_SVH
`define TETRIS_AI_DEFS_SVH

// grid size, row 0 is the top
`define TAI_ROWS 20
`define TAI_COLS 10

// field widths
`define TAI_HEIGHT_W 5
`define TAI_FEAT_W 8
`define TAI_SCORE_W 16
`define TAI_IDX_W 4

// score weights
`define TAI_W_LINES 8
`define TAI_W_HEIGHT 1
`define TAI_W_HOLES 4
`define TAI_W_BUMP 1

`endif

// File: hw/tetris_ai_pkg.sv
`include "tetris_ai_defs.svh"

package tetris_ai_pkg;

    // one bit per cell, 1 means filled
    typedef logic [`TAI_ROWS-1:0][`TAI_COLS-1:0] grid_t;

    typedef enum logic [1:0] {
        CLR_IDLE,
        CLR_SCAN,
        CLR_DONE
    } clear_state_t;

    typedef enum logic [2:0] {
        EXT_IDLE,
        EXT_LINES,
        EXT_COLUMN,
        EXT_SUM,
        EXT_DONE
    } extract_state_t;

    typedef enum logic [1:0] {
        TOP_IDLE,
        TOP_BUSY,
        TOP_ACK
    } top_state_t;

endpackage

// File: hw/line_clear.sv
`timescale 1ns/1ps
`include "tetris_ai_defs.svh"

module line_clear (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  tetris_ai_pkg::grid_t  grid_in,
    output logic                  ack,
    output tetris_ai_pkg::grid_t  grid_out,
    output logic [2:0]            lines
);

    localparam int ROW_W = $clog2(`TAI_ROWS);

    tetris_ai_pkg::clear_state_t state;

    tetris_ai_pkg::grid_t src;
    tetris_ai_pkg::grid_t dst;
    logic [ROW_W-1:0] src_row;
    logic [ROW_W-1:0] dst_row;
    logic [2:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= tetris_ai_pkg::CLR_IDLE;
        end else begin
            case (state)
                tetris_ai_pkg::CLR_IDLE: begin
                    if (req) begin
                        state <= tetris_ai_pkg::CLR_SCAN;
                    end
                end
                tetris_ai_pkg::CLR_SCAN: begin
                    if (src_row == '0) begin
                        state <= tetris_ai_pkg::CLR_DONE;
                    end
                end
                tetris_ai_pkg::CLR_DONE: begin
                    if (!req) begin
                        state <= tetris_ai_pkg::CLR_IDLE;
                    end
                end
                default: state <= tetris_ai_pkg::CLR_IDLE;
            endcase
        end
    end

    // bottom to top, surviving rows drop to the next free row
    always_ff @(posedge clk) begin
        if (state == tetris_ai_pkg::CLR_IDLE && req) begin
            src     <= grid_in;
            dst     <= '0;
            src_row <= ROW_W'(`TAI_ROWS - 1);
            dst_row <= ROW_W'(`TAI_ROWS - 1);
            count   <= '0;
        end else if (state == tetris_ai_pkg::CLR_SCAN) begin
            if (&src[src_row]) begin
                count <= count + 3'd1;
            end else begin
                dst[dst_row] <= src[src_row];
                dst_row      <= dst_row - ROW_W'(1);
            end
            src_row <= src_row - ROW_W'(1);
        end
    end

    assign ack      = (state == tetris_ai_pkg::CLR_DONE);
    assign grid_out = dst;
    assign lines    = count;

endmodule

// File: hw/feature_extract.sv
`timescale 1ns/1ps
`include "tetris_ai_defs.svh"

module feature_extract (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  tetris_ai_pkg::grid_t   grid,
    output logic                   ack,
    output logic [`TAI_FEAT_W-1:0] lines_cleared,
    output logic [`TAI_FEAT_W-1:0] holes,
    output logic [`TAI_FEAT_W-1:0] bumpiness,
    output logic [`TAI_FEAT_W-1:0] height_sum
);

    localparam int COL_W = $clog2(`TAI_COLS);
    localparam int HW    = `TAI_HEIGHT_W;
    localparam int FW    = `TAI_FEAT_W;

    tetris_ai_pkg::extract_state_t state;

    logic                 clear_req;
    logic                 clear_ack;
    tetris_ai_pkg::grid_t clear_grid;
    logic [2:0]           clear_lines;

    tetris_ai_pkg::grid_t work;
    logic [COL_W-1:0]     col;
    logic [`TAI_COLS-1:0][HW-1:0] heights;

    logic [FW-1:0] lines_r;
    logic [FW-1:0] holes_r;
    logic [FW-1:0] bump_r;
    logic [FW-1:0] hsum_r;

    logic          seen;
    logic [HW-1:0] col_height;
    logic [HW-1:0] col_holes;
    logic [HW-1:0] diff;
    logic [FW-1:0] sum_h;
    logic [FW-1:0] sum_b;

    line_clear line_clear_i (
        .clk      (clk),
        .rst      (rst),
        .req      (clear_req),
        .grid_in  (grid),
        .ack      (clear_ack),
        .grid_out (clear_grid),
        .lines    (clear_lines)
    );

    assign clear_req = (state == tetris_ai_pkg::EXT_LINES);

    ////////////////////////////////////////
    // fsm
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= tetris_ai_pkg::EXT_IDLE;
        end else begin
            case (state)
                tetris_ai_pkg::EXT_IDLE: begin
                    // line clear must have dropped its ack first
                    if (req && !clear_ack) begin
                        state <= tetris_ai_pkg::EXT_LINES;
                    end
                end
                tetris_ai_pkg::EXT_LINES: begin
                    if (clear_ack) begin
                        state <= tetris_ai_pkg::EXT_COLUMN;
                    end
                end
                tetris_ai_pkg::EXT_COLUMN: begin
                    if (col == COL_W'(`TAI_COLS - 1)) begin
                        state <= tetris_ai_pkg::EXT_SUM;
                    end
                end
                tetris_ai_pkg::EXT_SUM: state <= tetris_ai_pkg::EXT_DONE;
                tetris_ai_pkg::EXT_DONE: begin
                    if (!req) begin
                        state <= tetris_ai_pkg::EXT_IDLE;
                    end
                end
                default: state <= tetris_ai_pkg::EXT_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // column scan
    ////////////////////////////////////////

    // top down, every empty cell under the first filled one is a hole
    always_comb begin
        seen       = 1'b0;
        col_height = '0;
        col_holes  = '0;
        for (int r = 0; r < `TAI_ROWS; r++) begin
            if (work[r][col]) begin
                if (!seen) begin
                    col_height = HW'(`TAI_ROWS - r);
                end
                seen = 1'b1;
            end else if (seen) begin
                col_holes = col_holes + HW'(1);
            end
        end
    end

    always_comb begin
        sum_h = '0;
        sum_b = '0;
        diff  = '0;
        for (int c = 0; c < `TAI_COLS; c++) begin
            sum_h = sum_h + FW'(heights[c]);
        end
        for (int c = 0; c < `TAI_COLS - 1; c++) begin
            diff = (heights[c] > heights[c+1]) ? heights[c] - heights[c+1]
                                               : heights[c+1] - heights[c];
            sum_b = sum_b + FW'(diff);
        end
    end

    always_ff @(posedge clk) begin
        if (state == tetris_ai_pkg::EXT_LINES && clear_ack) begin
            work    <= clear_grid;
            lines_r <= FW'(clear_lines);
            holes_r <= '0;
            col     <= '0;
        end
        if (state == tetris_ai_pkg::EXT_COLUMN) begin
            heights[col] <= col_height;
            holes_r      <= holes_r + FW'(col_holes);
            col          <= col + COL_W'(1);
        end
        if (state == tetris_ai_pkg::EXT_SUM) begin
            bump_r <= sum_b;
            hsum_r <= sum_h;
        end
    end

    assign ack           = (state == tetris_ai_pkg::EXT_DONE);
    assign lines_cleared = lines_r;
    assign holes         = holes_r;
    assign bumpiness     = bump_r;
    assign height_sum    = hsum_r;

endmodule

// File: hw/move_score.sv
`timescale 1ns/1ps
`include "tetris_ai_defs.svh"

module move_score (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           update,
    input  logic                           first,
    input  logic [`TAI_FEAT_W-1:0]         lines_cleared,
    input  logic [`TAI_FEAT_W-1:0]         holes,
    input  logic [`TAI_FEAT_W-1:0]         bumpiness,
    input  logic [`TAI_FEAT_W-1:0]         height_sum,
    output logic signed [`TAI_SCORE_W-1:0] score,
    output logic signed [`TAI_SCORE_W-1:0] best_score,
    output logic [`TAI_IDX_W-1:0]          best_index
);

    localparam int SW = `TAI_SCORE_W;
    localparam int IW = `TAI_IDX_W;

    localparam logic signed [SW-1:0] W_LINES  = SW'(`TAI_W_LINES);
    localparam logic signed [SW-1:0] W_HEIGHT = SW'(`TAI_W_HEIGHT);
    localparam logic signed [SW-1:0] W_HOLES  = SW'(`TAI_W_HOLES);
    localparam logic signed [SW-1:0] W_BUMP   = SW'(`TAI_W_BUMP);

    logic signed [SW-1:0] lines_ext;
    logic signed [SW-1:0] holes_ext;
    logic signed [SW-1:0] bump_ext;
    logic signed [SW-1:0] height_ext;

    logic [IW-1:0] cand_idx;
    logic [IW-1:0] idx_now;
    logic signed [SW-1:0] best_r;
    logic [IW-1:0] best_idx_r;

    assign lines_ext  = SW'(lines_cleared);
    assign holes_ext  = SW'(holes);
    assign bump_ext   = SW'(bumpiness);
    assign height_ext = SW'(height_sum);

    assign score = W_LINES * lines_ext - W_HEIGHT * height_ext
                 - W_HOLES * holes_ext - W_BUMP * bump_ext;

    // index of the candidate being scored
    assign idx_now = first ? '0 : cand_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand_idx   <= '0;
            best_r     <= '0;
            best_idx_r <= '0;
        end else if (update) begin
            cand_idx <= idx_now + IW'(1);
            // strict compare, a tie keeps the earlier one
            if (first || score > best_r) begin
                best_r     <= score;
                best_idx_r <= idx_now;
            end
        end
    end

    assign best_score = best_r;
    assign best_index = best_idx_r;

endmodule

// File: hw/tetris_ai_top.sv
`timescale 1ns/1ps
`include "tetris_ai_defs.svh"

module tetris_ai_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic                           last,
    input  tetris_ai_pkg::grid_t           grid,
    output logic                           ack,
    output logic                           round_done,
    output logic [`TAI_FEAT_W-1:0]         lines_cleared,
    output logic [`TAI_FEAT_W-1:0]         holes,
    output logic [`TAI_FEAT_W-1:0]         bumpiness,
    output logic [`TAI_FEAT_W-1:0]         height_sum,
    output logic signed [`TAI_SCORE_W-1:0] score,
    output logic signed [`TAI_SCORE_W-1:0] best_score,
    output logic [`TAI_IDX_W-1:0]          best_index
);

    tetris_ai_pkg::top_state_t state;

    logic extract_req;
    logic extract_ack;
    logic update;
    logic last_r;
    logic new_round;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= tetris_ai_pkg::TOP_IDLE;
            last_r    <= 1'b0;
            new_round <= 1'b1;
        end else begin
            case (state)
                tetris_ai_pkg::TOP_IDLE: begin
                    if (req && !extract_ack) begin
                        state  <= tetris_ai_pkg::TOP_BUSY;
                        last_r <= last;
                    end
                end
                tetris_ai_pkg::TOP_BUSY: begin
                    if (extract_ack) begin
                        state <= tetris_ai_pkg::TOP_ACK;
                    end
                end
                tetris_ai_pkg::TOP_ACK: begin
                    if (!req) begin
                        state     <= tetris_ai_pkg::TOP_IDLE;
                        new_round <= last_r;
                    end
                end
                default: state <= tetris_ai_pkg::TOP_IDLE;
            endcase
        end
    end

    // best is registered on update, ack follows a cycle later
    assign update      = (state == tetris_ai_pkg::TOP_BUSY) && extract_ack;
    assign extract_req = (state != tetris_ai_pkg::TOP_IDLE);
    assign ack         = (state == tetris_ai_pkg::TOP_ACK);
    assign round_done  = ack && last_r;

    feature_extract feature_extract_i (
        .clk           (clk),
        .rst           (rst),
        .req           (extract_req),
        .grid          (grid),
        .ack           (extract_ack),
        .lines_cleared (lines_cleared),
        .holes         (holes),
        .bumpiness     (bumpiness),
        .height_sum    (height_sum)
    );

    move_score move_score_i (
        .clk           (clk),
        .rst           (rst),
        .update        (update),
        .first         (new_round),
        .lines_cleared (lines_cleared),
        .holes         (holes),
        .bumpiness     (bumpiness),
        .height_sum    (height_sum),
        .score         (score),
        .best_score    (best_score),
        .best_index    (best_index)
    );

endmodule

// File: sim/tetris_ai_model.svh
`ifndef TETRIS_AI_MODEL_SVH
`define TETRIS_AI_MODEL_SVH

// drop every full row, the others keep their order and settle at the bottom
function automatic tetris_ai_pkg::grid_t compact_rows(input tetris_ai_pkg::grid_t g,
                                                     output int full);
    tetris_ai_pkg::grid_t packed_grid;
    int next_free;
    packed_grid = '0;
    full = 0;
    next_free = `TAI_ROWS - 1;
    for (int r = `TAI_ROWS - 1; r >= 0; r--) begin
        if (g[r] == {`TAI_COLS{1'b1}}) begin
            full++;
        end else begin
            packed_grid[next_free] = g[r];
            next_free--;
        end
    end
    return packed_grid;
endfunction

function automatic void board_features(input tetris_ai_pkg::grid_t g, output int lines,
                                       output int holes, output int bump, output int hsum);
    tetris_ai_pkg::grid_t c;
    int height [`TAI_COLS];
    int above;
    c = compact_rows(g, lines);
    holes = 0;
    bump = 0;
    hsum = 0;
    for (int col = 0; col < `TAI_COLS; col++) begin
        height[col] = 0;
        for (int r = 0; r < `TAI_ROWS; r++) begin
            // tallest filled cell sets the height
            if (c[r][col] && `TAI_ROWS - r > height[col]) begin
                height[col] = `TAI_ROWS - r;
            end
            // empty cell with anything filled above it
            above = 0;
            for (int k = 0; k < r; k++) begin
                above = above + int'(c[k][col]);
            end
            if (!c[r][col] && above > 0) begin
                holes++;
            end
        end
        hsum = hsum + height[col];
    end
    for (int col = 0; col + 1 < `TAI_COLS; col++) begin
        bump = bump + ((height[col] > height[col+1]) ? height[col] - height[col+1]
                                                     : height[col+1] - height[col]);
    end
endfunction

function automatic int weighted_score(input int lines, input int holes, input int bump,
                                      input int hsum);
    return `TAI_W_LINES * lines - `TAI_W_HEIGHT * hsum - `TAI_W_HOLES * holes
         - `TAI_W_BUMP * bump;
endfunction

`endif

// File: sim/tetris_ai_tb.sv
`timescale 1ns/1ps
`include "tetris_ai_defs.svh"

module tetris_ai_tb;

    localparam logic [15:0] SEED = 16'd52557;
    localparam int TIMEOUT = 200;
    localparam int N_RANDOM = 10;
    localparam int N_ROUNDS = 3;
    localparam int N_CANDS = 5;

    logic clk;
    logic rst;
    logic req;
    logic last;
    tetris_ai_pkg::grid_t grid;
    logic ack;
    logic round_done;
    logic [`TAI_FEAT_W-1:0] lines_cleared;
    logic [`TAI_FEAT_W-1:0] holes;
    logic [`TAI_FEAT_W-1:0] bumpiness;
    logic [`TAI_FEAT_W-1:0] height_sum;
    logic signed [`TAI_SCORE_W-1:0] score;
    logic signed [`TAI_SCORE_W-1:0] best_score;
    logic [`TAI_IDX_W-1:0] best_index;

    logic [15:0] lfsr;
    string test_name;
    int exp_lines, exp_holes, exp_bump, exp_hsum, exp_score, exp_best, exp_index;
    logic exp_last;
    int run_best, run_index, round_pos;
    int errors, tests, candidates, err_start, cand_start;
    logic timed_out;

    `include "tetris_ai_model.svh"

    tetris_ai_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .last          (last),
        .grid          (grid),
        .ack           (ack),
        .round_done    (round_done),
        .lines_cleared (lines_cleared),
        .holes         (holes),
        .bumpiness     (bumpiness),
        .height_sum    (height_sum),
        .score         (score),
        .best_score    (best_score),
        .best_index    (best_index)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic report_value(input string field, input int expected, input int actual);
        $display("Error: %s %s expected %0d actual %0d", test_name, field, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        errors++;
    endtask

    assert property (@(posedge clk) rst |-> !ack && !round_done)
        else report_failure("ack or round_done was high during reset");
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(lines_cleared) == exp_lines)
        else report_value("lines_cleared", exp_lines, int'(lines_cleared));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(holes) == exp_holes)
        else report_value("holes", exp_holes, int'(holes));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(bumpiness) == exp_bump)
        else report_value("bumpiness", exp_bump, int'(bumpiness));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(height_sum) == exp_hsum)
        else report_value("height_sum", exp_hsum, int'(height_sum));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(score) == exp_score)
        else report_value("score", exp_score, int'(score));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(best_score) == exp_best)
        else report_value("best_score", exp_best, int'(best_score));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> int'(best_index) == exp_index)
        else report_value("best_index", exp_index, int'(best_index));
    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> round_done == exp_last)
        else report_value("round_done", int'(exp_last), int'(round_done));

    // back-pressure: results frozen, ack held, ack drops only after req
    assert property (@(posedge clk) disable iff (rst) ack && $past(ack) |->
        $stable(lines_cleared) && $stable(holes) && $stable(bumpiness) && $stable(height_sum)
        && $stable(score) && $stable(best_score) && $stable(best_index) && $stable(round_done))
        else report_failure("an output changed while ack was held");
    assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
        else report_failure("ack dropped while req was still high");
    assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
        else report_failure("ack fell before req fell");

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    // sparse middle, dense bottom, some bottom rows full
    function automatic tetris_ai_pkg::grid_t random_board();
        tetris_ai_pkg::grid_t g;
        g = '0;
        for (int r = 8; r < `TAI_ROWS; r++) begin
            for (int c = 0; c < `TAI_COLS; c++) begin
                if (r >= 14) begin
                    g[r][c] = lfsr_bit() | lfsr_bit();
                end else begin
                    g[r][c] = lfsr_bit() & lfsr_bit();
                end
            end
            if (r >= 16 && lfsr_bit()) begin
                g[r] = '1;
            end
        end
        return g;
    endfunction

    task automatic flag_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic run_candidate(input tetris_ai_pkg::grid_t board, input logic is_last,
                                 input int hold);
        int n_lines, n_holes, n_bump, n_hsum;
        int value;
        int waited;
        // a stuck handshake skips the remaining candidates
        if (timed_out) begin
            return;
        end
        board_features(board, n_lines, n_holes, n_bump, n_hsum);
        value = weighted_score(n_lines, n_holes, n_bump, n_hsum);
        // a tie keeps the earlier candidate
        if (round_pos == 0 || value > run_best) begin
            run_best = value;
            run_index = round_pos;
        end
        exp_lines = n_lines;
        exp_holes = n_holes;
        exp_bump = n_bump;
        exp_hsum = n_hsum;
        exp_score = value;
        exp_best = run_best;
        exp_index = run_index;
        exp_last = is_last;
        grid = board;
        last = is_last;
        req = 1'b1;
        waited = 0;
        while (!ack && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            flag_timeout("ack never rose after req");
            return;
        end
        repeat (hold) @(negedge clk);
        req = 1'b0;
        waited = 0;
        while (ack && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            flag_timeout("ack stayed high after req fell");
            return;
        end
        round_pos = is_last ? 0 : round_pos + 1;
        candidates++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_start = errors;
        cand_start = candidates;
    endtask

    task automatic end_test();
        $display("%s: %0d candidates, %0d errors", test_name, candidates - cand_start,
                 errors - err_start);
        tests++;
    endtask

    initial begin
        tetris_ai_pkg::grid_t g;
        tetris_ai_pkg::grid_t saved;
        rst = 1'b1;
        req = 1'b0;
        last = 1'b0;
        grid = '0;
        lfsr = SEED;
        test_name = "reset";
        errors = 0;
        tests = 0;
        candidates = 0;
        round_pos = 0;
        run_best = 0;
        run_index = 0;
        timed_out = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        begin_test("empty_board");
        run_candidate('0, 1'b1, 0);
        end_test();

        begin_test("full_rows");
        for (int n = 1; n <= 4; n++) begin
            g = '0;
            g[`TAI_ROWS-1] = 10'b1111011111;
            for (int r = 1; r <= n; r++) begin
                g[`TAI_ROWS-1-r] = '1;
            end
            g[`TAI_ROWS-2-n][0] = 1'b1;
            run_candidate(g, 1'b1, 0);
        end
        end_test();

        begin_test("hand_holes");
        g = '0;
        // separated gaps in column 2, a stacked pair in column 7
        g[10][2] = 1'b1;
        g[13][2] = 1'b1;
        g[15][7] = 1'b1;
        g[16][7] = 1'b1;
        g[18][7] = 1'b1;
        g[18][0] = 1'b1;
        g[19][0] = 1'b1;
        run_candidate(g, 1'b1, 0);
        g = '0;
        // cap over a cleared row, holes counted after compaction
        g[14][5] = 1'b1;
        g[15] = '1;
        run_candidate(g, 1'b1, 1);
        end_test();

        begin_test("random_boards");
        for (int k = 0; k < N_RANDOM; k++) begin
            run_candidate(random_board(), 1'b1, k % 3);
        end
        end_test();

        begin_test("rounds");
        saved = '0;
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int k = 0; k < N_CANDS; k++) begin
                g = random_board();
                if (r == 1 && (k == 1 || k == 3)) begin
                    g = '0;
                end
                if (k == 0) begin
                    saved = g;
                end
                if (r == 2 && k == 2) begin
                    g = saved;
                end
                run_candidate(g, k == N_CANDS - 1, k % 2);
            end
        end
        end_test();

        begin_test("back_pressure");
        run_candidate(random_board(), 1'b0, 6);
        run_candidate(random_board(), 1'b1, 3);
        end_test();

        $display("tests %0d, candidates %0d, errors %0d", tests, candidates, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
+incdir+sim
hw/tetris_ai_pkg.sv
hw/line_clear.sv
hw/feature_extract.sv
hw/move_score.sv
hw/tetris_ai_top.sv
sim/tetris_ai_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tetris_ai_tb \
    -o tetris_ai_sim || exit 1

out="$(./obj_dir/tetris_ai_sim)"
echo "$out"

echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1
